//--- project.f
+incdir+rtl
+incdir+tests
rtl/mlpPkg.sv
rtl/denseNeuron.sv
rtl/classSelect.sv
rtl/mlpClassifier.sv
tests/clockGen.sv
tests/mlpClassifierTb.sv

//--- Makefile
# Verilator build and run of the MLP classifier testbench

VERILATOR ?= verilator
TOP ?= mlpClassifierTb
FILELIST ?= project.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

//--- tests/mlpModel.svh
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

`include "mlp_settings.svh"

localparam mlpPkg::features_t H_W [`MLP_HIDDEN] = '{`MLP_H0_W, `MLP_H1_W, `MLP_H2_W, `MLP_H3_W};
localparam int H_B [`MLP_HIDDEN] = '{int'(`MLP_H0_B), int'(`MLP_H1_B), int'(`MLP_H2_B),
	int'(`MLP_H3_B)};
localparam logic [31:0] O_W [`MLP_CLASSES] = '{`MLP_O0_W, `MLP_O1_W, `MLP_O2_W};
localparam int O_B [`MLP_CLASSES] = '{int'(`MLP_O0_B), int'(`MLP_O1_B), int'(`MLP_O2_B)};

// bias plus the weighted inputs, element i of each vector in byte i
function automatic int neuronSum(input mlpPkg::features_t inVec, input mlpPkg::features_t wVec,
	input int fanIn, input int bias);
	int acc;
	acc = bias;
	for (int i = 0; i < fanIn; i++)
		acc += int'($signed(inVec[8*i +: 8])) * int'($signed(wVec[8*i +: 8]));
	return acc;
endfunction

// relu, round half up at the field LSB, clamp to the saturation value
function automatic int activate(input int acc);
	int r;
	if (acc < 0)
		return 0;
	r = (acc >>> `MLP_FRAC_LSB) + ((acc >>> (`MLP_FRAC_LSB - 1)) & 1);
	return (r > int'(`MLP_SAT_MAX)) ? int'(`MLP_SAT_MAX) : r;
endfunction

function automatic mlpPkg::hiddenVec_t hiddenLayer(input mlpPkg::features_t f);
	mlpPkg::hiddenVec_t h;
	for (int k = 0; k < `MLP_HIDDEN; k++)
		h[8*k +: 8] = 8'(activate(neuronSum(f, H_W[k], `MLP_FEATURES, H_B[k])));
	return h;
endfunction

// raw sum of output neuron j
function automatic int outputSum(input mlpPkg::hiddenVec_t h, input int j);
	return neuronSum(mlpPkg::features_t'(h), mlpPkg::features_t'(O_W[j]), `MLP_HIDDEN, O_B[j]);
endfunction

function automatic mlpPkg::scoreVec_t outputLayer(input mlpPkg::hiddenVec_t h);
	mlpPkg::scoreVec_t s;
	for (int j = 0; j < `MLP_CLASSES; j++)
		s[8*j +: 8] = 8'(activate(outputSum(h, j)));
	return s;
endfunction

// strict compare, so the lowest index wins a tie
function automatic mlpPkg::classIndex_t argmax(input mlpPkg::scoreVec_t s);
	int best;
	best = 0;
	for (int j = 1; j < `MLP_CLASSES; j++)
		if (s[8*j +: 8] > s[8*best +: 8])
			best = j;
	return mlpPkg::classIndex_t'(best);
endfunction

`endif

//--- tests/mlpClassifierTb.sv
`timescale 1ns/1ps
`include "mlp_settings.svh"

module mlpClassifierTb;

	localparam int HIDDEN_LAT = 3;
	localparam int SCORE_LAT = 6;
	localparam int CLASS_LAT = 7;
	localparam int CYCLE_LIMIT = 1000; // about 250 cycles of tests
	localparam int N_TESTS = 6; // slot 0 collects the idle cycles

	typedef struct packed {
		mlpPkg::hiddenVec_t hidden;
		mlpPkg::scoreVec_t scores;
		mlpPkg::classIndex_t cls;
		mlpPkg::activation_t win;
		int test;
	} expect_t;

	logic clk;
	logic reset;
	mlpPkg::features_t features;
	mlpPkg::scoreVec_t scores;
	mlpPkg::classIndex_t classIndex;
	mlpPkg::activation_t winScore;

	expect_t history[$]; // newest entry at the back
	string testName [N_TESTS];
	int checkCount [N_TESTS];
	int errCount [N_TESTS];
	int currentTest;
	int testsFailed;
	int totalErrors;
	int cycles = 0;
	mlpPkg::features_t clipVector;
	bit clipFound;

	`include "mlpModel.svh"

	clockGen clockGen0 (
		.clk(clk),
		.reset(reset)
	);

	mlpClassifier dut0 (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores),
		.classIndex(classIndex),
		.winScore(winScore)
	);

	task automatic checkValue(input int test, input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount[test]++;
		assert (actual === expected)
		else
		begin
			errCount[test]++;
			$display("ERR %s %s expected %0h actual %0h", testName[test], what, expected, actual);
		end
	endtask

	task automatic stimulusFault(input int test, input string msg);
		errCount[test]++;
		$display("%s: %s", testName[test], msg);
	endtask

	// outputs at this falling edge belong to vectors 3, 6 and 7 cycles back
	task automatic checkOutputs();
		expect_t e;
		int n;
		n = history.size();
		if (n >= HIDDEN_LAT)
		begin
			e = history[n - HIDDEN_LAT];
			checkValue(e.test, "hidden", 32'(e.hidden), 32'(dut0.hiddenAct));
		end
		if (n >= SCORE_LAT)
		begin
			e = history[n - SCORE_LAT];
			checkValue(e.test, "scores", 32'(e.scores), 32'(scores));
		end
		if (n >= CLASS_LAT)
		begin
			e = history[n - CLASS_LAT];
			checkValue(e.test, "classIndex", 32'(e.cls), 32'(classIndex));
			checkValue(e.test, "winScore", 32'(e.win), 32'(winScore));
		end
	endtask

	task automatic applyVector(input mlpPkg::features_t v);
		expect_t e;
		@(negedge clk);
		checkOutputs();
		e.hidden = hiddenLayer(v);
		e.scores = outputLayer(e.hidden);
		e.cls = argmax(e.scores);
		e.win = mlpPkg::activation_t'(e.scores[8*e.cls +: 8]);
		e.test = currentTest;
		features = v;
		history.push_back(e);
		if (history.size() > CLASS_LAT)
			void'(history.pop_front());
	endtask

	function automatic mlpPkg::features_t randomFeatures(input int span);
		mlpPkg::features_t v;
		for (int i = 0; i < `MLP_FEATURES; i++)
			v[8*i +: 8] = 8'(int'($urandom_range(2 * span - 1)) - span);
		return v;
	endfunction

	function automatic bit allHiddenNegative(input mlpPkg::features_t v);
		for (int k = 0; k < `MLP_HIDDEN; k++)
			if (neuronSum(v, H_W[k], `MLP_FEATURES, H_B[k]) >= 0)
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic startTest(input int id, input string name);
		currentTest = id;
		testName[id] = name;
	endtask

	task automatic reportTest(input int id);
		if (errCount[id] != 0)
			testsFailed++;
		$display("test %s: %0d checks, %0d errors", testName[id], checkCount[id], errCount[id]);
	endtask

	// idle cycles until the last vector of the test has left the pipeline
	task automatic finishTest();
		int id;
		id = currentTest;
		currentTest = 0;
		repeat (CLASS_LAT) applyVector('0);
		reportTest(id);
	endtask

	task automatic resetTest();
		startTest(1, "reset");
		@(posedge clk);
		while (reset)
		begin
			@(negedge clk);
			checkValue(1, "scores", '0, 32'(scores));
			checkValue(1, "classIndex", '0, 32'(classIndex));
			checkValue(1, "winScore", '0, 32'(winScore));
		end
		reportTest(1);
		currentTest = 0;
	endtask

	task automatic randomTest();
		startTest(2, "random");
		repeat (200) applyVector(randomFeatures(128));
		finishTest();
	endtask

	task automatic saturationTest();
		mlpPkg::features_t v;
		mlpPkg::hiddenVec_t h;
		startTest(3, "saturation");
		for (int k = 0; k < `MLP_HIDDEN; k++)
		begin
			for (int i = 0; i < `MLP_FEATURES; i++)
				v[8*i +: 8] = ($signed(H_W[k][8*i +: 8]) < 0) ? 8'h80 : 8'h7f;
			h = hiddenLayer(v);
			if (h[8*k +: 8] != 8'd127)
				stimulusFault(3, $sformatf("vector %0d does not saturate hidden neuron %0d", k, k));
			applyVector(v);
			applyVector(~v); // every feature against its weight
		end
		clipFound = 1'b0;
		for (int t = 0; t < 2000 && !clipFound; t++)
		begin
			v = randomFeatures(128);
			clipFound = allHiddenNegative(v);
		end
		if (clipFound)
		begin
			clipVector = v;
			applyVector(v); // scores are the bias-only outputs
		end
		else
			stimulusFault(3, "no vector found that drives all hidden sums negative");
		finishTest();
	endtask

	task automatic roundingTest();
		mlpPkg::features_t v;
		mlpPkg::scoreVec_t s;
		int acc;
		bit found;
		startTest(4, "rounding");
		for (int j = 0; j < `MLP_CLASSES; j++)
		begin
			found = 1'b0;
			for (int t = 0; t < 500 && !found; t++)
			begin
				v = randomFeatures(16);
				acc = outputSum(hiddenLayer(v), j);
				found = acc >= 0 && acc[`MLP_FRAC_LSB-1] && (acc >>> `MLP_FRAC_LSB) < 127;
			end
			if (!found)
				stimulusFault(4, $sformatf("no vector found that rounds output neuron %0d", j));
			else
			begin
				s = outputLayer(hiddenLayer(v));
				if (int'(s[8*j +: 8]) != (acc >>> `MLP_FRAC_LSB) + 1)
					stimulusFault(4, $sformatf("output neuron %0d is not rounded up", j));
				applyVector(v);
			end
		end
		finishTest();
	endtask

	task automatic tieTest();
		mlpPkg::features_t v;
		mlpPkg::scoreVec_t s;
		bit found;
		startTest(5, "tie");
		if (clipFound)
			applyVector(clipVector); // classes 0 and 2 tie on their biases
		found = 1'b0;
		for (int t = 0; t < 2000 && !found; t++)
		begin
			v = randomFeatures(128);
			s = outputLayer(hiddenLayer(v));
			found = s[15:8] == s[23:16] && s[15:8] > s[7:0];
		end
		if (found)
			applyVector(v);
		else
			stimulusFault(5, "no vector found where classes 1 and 2 tie for the top score");
		finishTest();
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("run timed out after %0d cycles", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial
	begin
		features = '0;
		currentTest = 0;
		testsFailed = 0;
		totalErrors = 0;
		testName[0] = "idle";
		void'($urandom(32'h89f5_2f77));
		resetTest();
		randomTest();
		saturationTest();
		roundingTest();
		tieTest();
		foreach (errCount[i])
			totalErrors += errCount[i];
		$display("tests: %0d passed, %0d failed, %0d errors in total",
			N_TESTS - 1 - testsFailed, testsFailed, totalErrors);
		if (totalErrors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter real PERIOD = 8.0,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0; // drops right after the last reset edge
	end

endmodule

//--- rtl/mlpClassifier.sv
`timescale 1ns/1ps
`include "mlp_settings.svh"

module mlpClassifier (
	input logic clk,
	input logic reset,
	input mlpPkg::features_t features,
	output wire mlpPkg::scoreVec_t scores, // 6 cycles after features
	output mlpPkg::classIndex_t classIndex, // 7 cycles after features
	output mlpPkg::activation_t winScore
);

	wire mlpPkg::hiddenVec_t hiddenAct;

	// hidden layer, every neuron sees all features
	denseNeuron #(
		.FANIN(`MLP_FEATURES),
		.WEIGHTS(`MLP_H0_W),
		.BIAS(`MLP_H0_B)
	) hidden0 (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.activation(hiddenAct[7:0])
	);

	denseNeuron #(
		.FANIN(`MLP_FEATURES),
		.WEIGHTS(`MLP_H1_W),
		.BIAS(`MLP_H1_B)
	) hidden1 (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.activation(hiddenAct[15:8])
	);

	denseNeuron #(
		.FANIN(`MLP_FEATURES),
		.WEIGHTS(`MLP_H2_W),
		.BIAS(`MLP_H2_B)
	) hidden2 (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.activation(hiddenAct[23:16])
	);

	denseNeuron #(
		.FANIN(`MLP_FEATURES),
		.WEIGHTS(`MLP_H3_W),
		.BIAS(`MLP_H3_B)
	) hidden3 (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.activation(hiddenAct[31:24])
	);

	// output layer
	denseNeuron #(
		.FANIN(`MLP_HIDDEN),
		.WEIGHTS(`MLP_O0_W),
		.BIAS(`MLP_O0_B)
	) out0 (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenAct),
		.activation(scores[7:0])
	);

	denseNeuron #(
		.FANIN(`MLP_HIDDEN),
		.WEIGHTS(`MLP_O1_W),
		.BIAS(`MLP_O1_B)
	) out1 (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenAct),
		.activation(scores[15:8])
	);

	denseNeuron #(
		.FANIN(`MLP_HIDDEN),
		.WEIGHTS(`MLP_O2_W),
		.BIAS(`MLP_O2_B)
	) out2 (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenAct),
		.activation(scores[23:16])
	);

	classSelect select0 (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.classIndex(classIndex),
		.winScore(winScore)
	);

endmodule

//--- rtl/classSelect.sv
`timescale 1ns/1ps
`include "mlp_settings.svh"

module classSelect (
	input logic clk,
	input logic reset,
	input mlpPkg::scoreVec_t scores,
	output mlpPkg::classIndex_t classIndex,
	output mlpPkg::activation_t winScore
);

	localparam int ACT_W = $bits(mlpPkg::activation_t);

	logic [ACT_W-1:0] bestScore; // unsigned, scores are never negative
	mlpPkg::classIndex_t bestIdx;

	// linear scan, strict compare keeps the lowest index on a tie
	always_comb
	begin
		bestIdx = '0;
		bestScore = scores[ACT_W-1:0];
		for (int i = 1; i < `MLP_CLASSES; i++)
		begin
			if (scores[ACT_W*i +: ACT_W] > bestScore)
			begin
				bestIdx = mlpPkg::classIndex_t'(i);
				bestScore = scores[ACT_W*i +: ACT_W];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIndex <= '0;
			winScore <= '0;
		end
		else
		begin
			classIndex <= bestIdx;
			winScore <= bestScore;
		end
	end

endmodule

//--- rtl/denseNeuron.sv
`timescale 1ns/1ps
`include "mlp_settings.svh"

module denseNeuron #(
	parameter int FANIN = `MLP_FEATURES,
	parameter logic [FANIN*8-1:0] WEIGHTS = '0,
	parameter mlpPkg::bias_t BIAS = '0
) (
	input logic clk,
	input logic reset,
	input mlpPkg::activation_t [FANIN-1:0] inputs,
	output mlpPkg::activation_t activation
);

	localparam int ACC_W = $bits(mlpPkg::accum_t);
	localparam int ACT_W = $bits(mlpPkg::activation_t);
	localparam int FIELD_MSB = `MLP_FRAC_LSB + ACT_W - 1;

	mlpPkg::activation_t [FANIN-1:0] inputsReg;
	mlpPkg::product_t products [FANIN];
	mlpPkg::accum_t sumNext;
	mlpPkg::accum_t accum;
	logic [ACT_W-1:0] field;
	logic [ACT_W-1:0] rounded;
	logic overRange;

	// stage 1, input capture
	always_ff @(posedge clk)
	begin
		if (reset)
			inputsReg <= '0;
		else
			inputsReg <= inputs;
	end

	// one signed multiplier per synapse
	for (genvar i = 0; i < FANIN; i++)
	begin : gMul
		localparam mlpPkg::weight_t W = WEIGHTS[8*i +: 8];

		assign products[i] = mlpPkg::product_t'(inputsReg[i]) * mlpPkg::product_t'(W);
	end

	// adder tree starts from the bias
	always_comb
	begin
		sumNext = mlpPkg::accum_t'(BIAS);
		for (int i = 0; i < FANIN; i++)
			sumNext = sumNext + mlpPkg::accum_t'(products[i]);
	end

	// stage 2, accumulator
	always_ff @(posedge clk)
	begin
		if (reset)
			accum <= '0;
		else
			accum <= sumNext;
	end

	assign field = accum[FIELD_MSB:`MLP_FRAC_LSB];
	assign rounded = field + ACT_W'(accum[`MLP_FRAC_LSB-1]); // round half up

	// Anything at or above the field sign bit is too big for a positive
	// 8-bit result. A round-up carry out of 127 lands there as well.
	assign overRange = (accum[ACC_W-2:FIELD_MSB] != '0) || rounded[ACT_W-1];

	// stage 3, ReLU with saturation
	always_ff @(posedge clk)
	begin
		if (reset)
			activation <= '0;
		else if (accum[ACC_W-1])
			activation <= '0; // negative sum clips
		else if (overRange)
			activation <= `MLP_SAT_MAX;
		else
			activation <= rounded;
	end

endmodule

//--- rtl/mlpPkg.sv
`include "mlp_settings.svh"

package mlpPkg;

	// scalar values of the datapath
	typedef logic signed [7:0] activation_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] product_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [22:0] accum_t; // fan-in up to 64

	// packed layer vectors, element 0 in the low byte
	typedef logic [`MLP_FEATURES*8-1:0] features_t;
	typedef logic [`MLP_HIDDEN*8-1:0] hiddenVec_t;
	typedef logic [`MLP_CLASSES*8-1:0] scoreVec_t;

	typedef logic [$clog2(`MLP_CLASSES)-1:0] classIndex_t;

endpackage

//--- rtl/mlp_settings.svh
`ifndef MLP_SETTINGS_SVH
`define MLP_SETTINGS_SVH

// network shape
`define MLP_FEATURES 10
`define MLP_HIDDEN 4
`define MLP_CLASSES 3

// output stage of every neuron
`define MLP_SAT_MAX 8'sd127
`define MLP_FRAC_LSB 6

// hidden layer weights, listed from weight 9 down to weight 0
`define MLP_H0_W {8'sd16, -8'sd34, -8'sd12, -8'sd14, 8'sd46, \
	8'sd38, 8'sd20, -8'sd24, 8'sd18, -8'sd44}
`define MLP_H1_W {-8'sd22, 8'sd30, 8'sd8, -8'sd40, 8'sd12, \
	-8'sd18, 8'sd36, 8'sd26, -8'sd10, 8'sd28}
`define MLP_H2_W {8'sd40, -8'sd6, 8'sd24, 8'sd14, -8'sd32, \
	8'sd20, -8'sd28, 8'sd10, 8'sd44, -8'sd16}
`define MLP_H3_W {-8'sd30, 8'sd12, -8'sd20, 8'sd34, 8'sd6, \
	-8'sd42, 8'sd16, 8'sd22, -8'sd8, 8'sd38}

// hidden layer biases
`define MLP_H0_B 16'sd512
`define MLP_H1_B (-16'sd256)
`define MLP_H2_B 16'sd128
`define MLP_H3_B 16'sd0

// output layer weights, weight 3 first
`define MLP_O0_W {8'sd12, -8'sd18, 8'sd26, 8'sd20}
`define MLP_O1_W {-8'sd16, 8'sd28, 8'sd14, -8'sd10}
`define MLP_O2_W {8'sd22, 8'sd10, -8'sd24, 8'sd16}

// output layer biases
`define MLP_O0_B 16'sd64
`define MLP_O1_B (-16'sd64)
`define MLP_O2_B 16'sd64

`endif
